// ==== fir_macros.svh ====
`ifndef FIR_MACROS_SVH
`define FIR_MACROS_SVH

// filter geometry, segment count must be a power of two
`define FIR_NUM_SEG 2
`define FIR_TAPS 4

// datapath widths
`define FIR_DATA_W 16
`define FIR_OUT_W 24

// register port
`define FIR_ADDR_W 6

// ctrl: bit 0 sine enable, bits 7:4 output shift
`define FIR_REG_CTRL 6'h00
// write only, arms one injected sample
`define FIR_REG_INJECT 6'h01
`define FIR_REG_RESULT 6'h02
`define FIR_REG_SHIFT_OUT 6'h03
// coefficient k of segment s at base + s*taps + k
`define FIR_REG_COEF_BASE 6'h10

`define FIR_SHIFT_RESET 4'd0

`endif

// ==== fir_pkg.sv ====
`include "fir_macros.svh"

package fir_pkg;

	// sample and coefficient words
	typedef logic signed [`FIR_DATA_W-1:0] sample_t;
	typedef logic signed [`FIR_DATA_W-1:0] coef_t;

	// partial sum of one segment
	typedef logic signed [`FIR_OUT_W-1:0] acc_t;

	// full sum out of the adder tree, one bit per tree level
	typedef logic signed [`FIR_OUT_W+$clog2(`FIR_NUM_SEG)-1:0] sum_t;

	typedef logic [`FIR_ADDR_W-1:0] reg_addr_t;

	// segment mac sequencer
	typedef enum logic [1:0] {
		seg_idle,
		seg_acc,
		seg_done
	} seg_state_t;

	// one period of a full scale sine, 16 points
	localparam sample_t sine_table [16] = '{
		16'sd0,      16'sd12539,  16'sd23170,  16'sd30273,
		16'sd32767,  16'sd30273,  16'sd23170,  16'sd12539,
		16'sd0,      -16'sd12539, -16'sd23170, -16'sd30273,
		-16'sd32767, -16'sd30273, -16'sd23170, -16'sd12539
	};

endpackage

// ==== fir_segment.sv ====
`timescale 1ns/10ps
`include "fir_macros.svh"

module fir_segment (
	input  logic                         clk_i,
	input  logic                         rst_ni,
	input  logic                         valid_i,
	input  fir_pkg::sample_t             sample_i,
	input  logic                         coef_we_i,
	input  logic [$clog2(`FIR_TAPS)-1:0] coef_idx_i,
	input  fir_pkg::coef_t               coef_data_i,
	output fir_pkg::sample_t             sample_shift_o,
	output logic                         valid_o,
	output fir_pkg::acc_t                acc_o
);

	localparam int TAP_W = $clog2(`FIR_TAPS);
	localparam logic [TAP_W-1:0] LAST_TAP = TAP_W'(`FIR_TAPS - 1);

	fir_pkg::sample_t line_q [`FIR_TAPS];
	fir_pkg::coef_t coef_q [`FIR_TAPS];
	fir_pkg::seg_state_t state_q;
	logic [TAP_W-1:0] tap_q;
	fir_pkg::acc_t acc_q;
	logic signed [2*`FIR_DATA_W-1:0] prod;

	// coefficient store, loaded from the register port
	always_ff @(posedge clk_i) begin
		if (coef_we_i) begin
			coef_q[coef_idx_i] <= coef_data_i;
		end
	end

	// delay line, newest sample at index 0
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			for (int k = 0; k < `FIR_TAPS; k++) begin
				line_q[k] <= '0;
			end
		end else if (valid_i && state_q == fir_pkg::seg_idle) begin
			line_q[0] <= sample_i;
			for (int k = 1; k < `FIR_TAPS; k++) begin
				line_q[k] <= line_q[k-1];
			end
		end
	end

	// oldest sample feeds the next segment
	assign sample_shift_o = line_q[`FIR_TAPS-1];

	// one full precision tap product per cycle
	always_comb begin
		prod = line_q[tap_q] * coef_q[tap_q];
	end

	// mac sequencer
	// idle -> acc for one cycle per tap -> done pulses valid_o
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= fir_pkg::seg_idle;
			tap_q <= '0;
			acc_q <= '0;
			valid_o <= 1'b0;
		end else begin
			valid_o <= 1'b0;
			case (state_q)
				fir_pkg::seg_idle: begin
					if (valid_i) begin
						acc_q <= '0;
						tap_q <= '0;
						state_q <= fir_pkg::seg_acc;
					end
				end
				fir_pkg::seg_acc: begin
					// partial sum wraps at the output width
					acc_q <= acc_q + fir_pkg::acc_t'(prod);
					tap_q <= tap_q + 1'b1;
					if (tap_q == LAST_TAP) begin
						state_q <= fir_pkg::seg_done;
					end
				end
				fir_pkg::seg_done: begin
					valid_o <= 1'b1;
					state_q <= fir_pkg::seg_idle;
				end
				default: begin
					state_q <= fir_pkg::seg_idle;
				end
			endcase
		end
	end

	// partial sum held for the adder tree
	always_ff @(posedge clk_i) begin
		if (state_q == fir_pkg::seg_done) begin
			acc_o <= acc_q;
		end
	end

endmodule

// ==== fir_adder_tree.sv ====
`timescale 1ns/10ps

module fir_adder_tree #(
	parameter int NUM_IN = 2
) (
	input  logic          clk_i,
	input  logic          rst_ni,
	input  fir_pkg::acc_t acc_i [NUM_IN],
	output fir_pkg::sum_t sum_o
);

	localparam int LEVELS = $clog2(NUM_IN);

	fir_pkg::sum_t leaf [NUM_IN];

	// sign extend the partial sums to the tree width
	always_comb begin
		for (int i = 0; i < NUM_IN; i++) begin
			leaf[i] = fir_pkg::sum_t'(acc_i[i]);
		end
	end

	generate
		if (LEVELS == 0) begin : g_pass
			// single segment, nothing to add
			assign sum_o = leaf[0];
		end else begin : g_tree
			// node_q[l][i] is pair sum i of level l
			fir_pkg::sum_t node_q [LEVELS][NUM_IN/2];

			always_ff @(posedge clk_i or negedge rst_ni) begin
				if (!rst_ni) begin
					for (int l = 0; l < LEVELS; l++) begin
						for (int i = 0; i < NUM_IN/2; i++) begin
							node_q[l][i] <= '0;
						end
					end
				end else begin
					for (int i = 0; i < NUM_IN/2; i++) begin
						node_q[0][i] <= leaf[2*i] + leaf[2*i+1];
					end
					// each level halves the node count
					for (int l = 1; l < LEVELS; l++) begin
						for (int i = 0; i < (NUM_IN >> (l + 1)); i++) begin
							node_q[l][i] <= node_q[l-1][2*i] + node_q[l-1][2*i+1];
						end
					end
				end
			end

			assign sum_o = node_q[LEVELS-1][0];
		end
	endgenerate

endmodule

// ==== fir_reg_file.sv ====
`timescale 1ns/10ps
`include "fir_macros.svh"

module fir_reg_file (
	input  logic                         clk_i,
	input  logic                         rst_ni,
	input  logic                         reg_we_i,
	input  fir_pkg::reg_addr_t           reg_addr_i,
	input  logic [31:0]                  reg_wdata_i,
	output logic [31:0]                  reg_rdata_o,
	output logic [`FIR_NUM_SEG-1:0]      coef_we_o,
	output logic [$clog2(`FIR_TAPS)-1:0] coef_idx_o,
	output fir_pkg::coef_t               coef_data_o,
	output logic [3:0]                   shift_amount_o,
	output logic                         sine_en_o,
	output logic                         inject_armed_o,
	output fir_pkg::sample_t             inject_sample_o,
	input  logic                         inject_take_i,
	input  logic                         result_we_i,
	input  fir_pkg::sum_t                result_i,
	input  logic                         shift_out_we_i,
	input  fir_pkg::sample_t             shift_out_i
);

	localparam int TAP_W = $clog2(`FIR_TAPS);
	localparam int NUM_COEF = `FIR_NUM_SEG * `FIR_TAPS;

	fir_pkg::reg_addr_t coef_off;
	logic coef_hit;
	fir_pkg::sum_t result_q;
	fir_pkg::sample_t shift_out_q;

	// coefficient window decode, offset splits into segment and tap
	always_comb begin
		coef_off = reg_addr_i - `FIR_REG_COEF_BASE;
		coef_hit = (reg_addr_i >= `FIR_REG_COEF_BASE) && (coef_off < `FIR_ADDR_W'(NUM_COEF));
		for (int s = 0; s < `FIR_NUM_SEG; s++) begin
			coef_we_o[s] = reg_we_i && coef_hit && (int'(coef_off >> TAP_W) == s);
		end
	end

	assign coef_idx_o = coef_off[TAP_W-1:0];
	assign coef_data_o = reg_wdata_i[`FIR_DATA_W-1:0];

	// control register
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			shift_amount_o <= `FIR_SHIFT_RESET;
			sine_en_o <= 1'b0;
		end else if (reg_we_i && reg_addr_i == `FIR_REG_CTRL) begin
			sine_en_o <= reg_wdata_i[0];
			shift_amount_o <= reg_wdata_i[7:4];
		end
	end

	// one shot injection, a new write wins over a take in the same cycle
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			inject_armed_o <= 1'b0;
		end else if (reg_we_i && reg_addr_i == `FIR_REG_INJECT) begin
			inject_armed_o <= 1'b1;
		end else if (inject_take_i) begin
			inject_armed_o <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (reg_we_i && reg_addr_i == `FIR_REG_INJECT) begin
			inject_sample_o <= reg_wdata_i[`FIR_DATA_W-1:0];
		end
	end

	// readback copies from the datapath
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			result_q <= '0;
			shift_out_q <= '0;
		end else begin
			if (result_we_i) begin
				result_q <= result_i;
			end
			if (shift_out_we_i) begin
				shift_out_q <= shift_out_i;
			end
		end
	end

	// read mux, signed values are sign extended
	always_comb begin
		case (reg_addr_i)
			`FIR_REG_CTRL: reg_rdata_o = {24'd0, shift_amount_o, 3'd0, sine_en_o};
			`FIR_REG_RESULT: reg_rdata_o = 32'(result_q);
			`FIR_REG_SHIFT_OUT: reg_rdata_o = 32'(shift_out_q);
			default: reg_rdata_o = '0;
		endcase
	end

endmodule

// ==== fir_sine_gen.sv ====
`timescale 1ns/10ps

module fir_sine_gen (
	input  logic             clk_i,
	input  logic             rst_ni,
	input  logic             step_i,
	output fir_pkg::sample_t sine_o
);

	// position in the 16 entry table, wraps after one period
	logic [3:0] idx_q;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			idx_q <= '0;
		end else if (step_i) begin
			idx_q <= idx_q + 4'd1;
		end
	end

	// current tone value, the next one appears after a step
	assign sine_o = fir_pkg::sine_table[idx_q];

endmodule

// ==== fir_parallel.sv ====
`timescale 1ns/10ps
`include "fir_macros.svh"

module fir_parallel (
	input  logic                          clk_i,
	input  logic                          rst_ni,
	input  logic                          valid_strobe_i,
	input  fir_pkg::sample_t              sample_i,
	input  logic                          reg_we_i,
	input  fir_pkg::reg_addr_t            reg_addr_i,
	input  logic [31:0]                   reg_wdata_i,
	output logic [31:0]                   reg_rdata_o,
	output logic                          valid_strobe_o,
	output logic signed [`FIR_OUT_W-1:0]  y_o
);

	localparam int NUM_SEG = `FIR_NUM_SEG;
	localparam int LAST = NUM_SEG - 1;
	localparam int TREE_LAT = $clog2(`FIR_NUM_SEG);

	// register file side
	logic [NUM_SEG-1:0] coef_we;
	logic [$clog2(`FIR_TAPS)-1:0] coef_idx;
	fir_pkg::coef_t coef_data;
	logic [3:0] shift_amount;
	logic sine_en;
	logic inject_armed;
	fir_pkg::sample_t inject_sample;
	logic inject_take;

	// input stage
	logic strobe_q;
	logic strobe_rise;
	logic start_q;

	// segment chain
	fir_pkg::sample_t seg_in_q [NUM_SEG];
	fir_pkg::sample_t seg_shift [NUM_SEG];
	logic [NUM_SEG-1:0] seg_valid;
	fir_pkg::acc_t seg_acc [NUM_SEG];
	logic seg_all_valid;

	// output stage
	fir_pkg::sum_t tree_sum;
	logic tree_wait_q;
	logic [3:0] tree_cnt_q;
	logic out_fire;
	fir_pkg::sample_t sine;

	fir_reg_file u_regs (
		.clk_i,
		.rst_ni,
		.reg_we_i,
		.reg_addr_i,
		.reg_wdata_i,
		.reg_rdata_o,
		.coef_we_o(coef_we),
		.coef_idx_o(coef_idx),
		.coef_data_o(coef_data),
		.shift_amount_o(shift_amount),
		.sine_en_o(sine_en),
		.inject_armed_o(inject_armed),
		.inject_sample_o(inject_sample),
		.inject_take_i(inject_take),
		.result_we_i(out_fire),
		.result_i(tree_sum),
		.shift_out_we_i(seg_all_valid),
		.shift_out_i(seg_shift[LAST])
	);

	assign strobe_rise = valid_strobe_i && !strobe_q;
	assign inject_take = strobe_rise && inject_armed;

	// all segments run in lockstep and finish together
	assign seg_all_valid = &seg_valid;

	// edge detect, sample capture and chaining between segments
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			strobe_q <= 1'b0;
			start_q <= 1'b0;
			for (int s = 0; s < NUM_SEG; s++) begin
				seg_in_q[s] <= '0;
			end
		end else begin
			strobe_q <= valid_strobe_i;
			start_q <= strobe_rise;
			if (strobe_rise) begin
				seg_in_q[0] <= inject_armed ? inject_sample : sample_i;
			end
			// oldest sample of segment s becomes next input of s+1
			if (seg_all_valid) begin
				for (int s = 1; s < NUM_SEG; s++) begin
					seg_in_q[s] <= seg_shift[s-1];
				end
			end
		end
	end

	for (genvar s = 0; s < NUM_SEG; s++) begin : g_seg
		fir_segment u_seg (
			.clk_i,
			.rst_ni,
			.valid_i(start_q),
			.sample_i(seg_in_q[s]),
			.coef_we_i(coef_we[s]),
			.coef_idx_i(coef_idx),
			.coef_data_i(coef_data),
			.sample_shift_o(seg_shift[s]),
			.valid_o(seg_valid[s]),
			.acc_o(seg_acc[s])
		);
	end

	fir_adder_tree #(
		.NUM_IN(NUM_SEG)
	) u_tree (
		.clk_i,
		.rst_ni,
		.acc_i(seg_acc),
		.sum_o(tree_sum)
	);

	fir_sine_gen u_sine (
		.clk_i,
		.rst_ni,
		.step_i(out_fire),
		.sine_o(sine)
	);

	// tree result is ready TREE_LAT cycles after the segments finish
	assign out_fire = (TREE_LAT == 0) ? seg_all_valid : (tree_wait_q && tree_cnt_q == '0);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			tree_wait_q <= 1'b0;
			tree_cnt_q <= '0;
			valid_strobe_o <= 1'b0;
			y_o <= '0;
		end else begin
			valid_strobe_o <= out_fire;
			if (seg_all_valid && TREE_LAT != 0) begin
				tree_wait_q <= 1'b1;
				tree_cnt_q <= 4'(TREE_LAT - 1);
			end else if (tree_wait_q) begin
				if (tree_cnt_q == '0) begin
					tree_wait_q <= 1'b0;
				end else begin
					tree_cnt_q <= tree_cnt_q - 4'd1;
				end
			end
			// low output bits of the sum, or the test tone
			if (out_fire) begin
				if (sine_en) begin
					y_o <= fir_pkg::acc_t'(sine) <<< shift_amount;
				end else begin
					y_o <= fir_pkg::acc_t'(tree_sum) <<< shift_amount;
				end
			end
		end
	end

endmodule

// ==== tb_fir_parallel.sv ====
`timescale 1ns/10ps
`include "fir_macros.svh"

module tb_fir_parallel;

	localparam int NUM_TAPS = `FIR_NUM_SEG * `FIR_TAPS;
	localparam int LATENCY = `FIR_TAPS + $clog2(`FIR_NUM_SEG) + 3;
	localparam int WAIT_LIMIT = 200;

	logic clk_i;
	logic rst_ni;
	logic valid_strobe_i;
	fir_pkg::sample_t sample_i;
	logic reg_we_i;
	fir_pkg::reg_addr_t reg_addr_i;
	logic [31:0] reg_wdata_i;
	logic [31:0] reg_rdata_o;
	logic valid_strobe_o;
	logic signed [`FIR_OUT_W-1:0] y_o;

	// reference model state
	fir_pkg::coef_t coef_m [NUM_TAPS];
	fir_pkg::sample_t hist_m [NUM_TAPS];
	logic [3:0] shift_m;
	logic sine_en_m;
	logic [3:0] sine_idx_m;
	integer seed;

	fir_parallel dut_i (
		.clk_i,
		.rst_ni,
		.valid_strobe_i,
		.sample_i,
		.reg_we_i,
		.reg_addr_i,
		.reg_wdata_i,
		.reg_rdata_o,
		.valid_strobe_o,
		.y_o
	);

	initial begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Mismatch at %0t: %s expected 0x%h, actual 0x%h",
				$time, name, exp, got);
			$display("TESTBENCH FAILED");
			$fatal(1, "value check failed");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at %0t: %s did not happen within %0d cycles",
			$time, what, WAIT_LIMIT);
		$display("TESTBENCH FAILED");
		$fatal(1, "wait timed out");
	endtask

	task automatic reg_write(input fir_pkg::reg_addr_t addr, input logic [31:0] data);
		@(negedge clk_i);
		reg_we_i = 1'b1;
		reg_addr_i = addr;
		reg_wdata_i = data;
		@(negedge clk_i);
		reg_we_i = 1'b0;
	endtask

	// combinational read data sampled in the low clock phase
	task automatic reg_read(input fir_pkg::reg_addr_t addr, output logic [31:0] data);
		@(negedge clk_i);
		reg_addr_i = addr;
		#5;
		data = reg_rdata_o;
	endtask

	// full N tap sum over the model history
	function automatic longint filter_sum();
		longint acc;
		acc = 0;
		for (int k = 0; k < NUM_TAPS; k++) begin
			acc += longint'(coef_m[k]) * longint'(hist_m[k]);
		end
		return acc;
	endfunction

	// next y_o from the low sum bits or from the current tone entry
	function automatic logic [`FIR_OUT_W-1:0] expected_y(input fir_pkg::sum_t sum);
		logic [`FIR_OUT_W-1:0] base;
		fir_pkg::sample_t tone;
		tone = fir_pkg::sine_table[sine_idx_m];
		if (sine_en_m) begin
			base = {{(`FIR_OUT_W-`FIR_DATA_W){tone[`FIR_DATA_W-1]}}, tone};
		end else begin
			base = sum[`FIR_OUT_W-1:0];
		end
		return base << shift_m;
	endfunction

	task automatic expect_quiet(input int n);
		repeat (n) begin
			@(negedge clk_i);
			check_value("valid_strobe_o", {31'd0, valid_strobe_o}, 32'd0);
		end
	endtask

	// port_x drives sample_i and used_x is what the filter should see
	task automatic send_sample(input fir_pkg::sample_t port_x, input fir_pkg::sample_t used_x,
			input int hold);
		int cycles;
		int negs;
		bit seen;
		longint acc;
		fir_pkg::sum_t sum;
		logic [31:0] rd;
		for (int k = NUM_TAPS - 1; k > 0; k--) begin
			hist_m[k] = hist_m[k-1];
		end
		hist_m[0] = used_x;
		acc = filter_sum();
		sum = fir_pkg::sum_t'(acc);
		@(negedge clk_i);
		sample_i = port_x;
		valid_strobe_i = 1'b1;
		cycles = 0;
		negs = 0;
		seen = 1'b0;
		// pulse expected LATENCY edges after the first posedge
		while (!seen && cycles < WAIT_LIMIT) begin
			@(posedge clk_i);
			@(negedge clk_i);
			negs++;
			if (negs == hold) begin
				valid_strobe_i = 1'b0;
			end
			if (valid_strobe_o) begin
				seen = 1'b1;
			end else begin
				cycles++;
			end
		end
		valid_strobe_i = 1'b0;
		if (!seen) begin
			report_timeout("valid_strobe_o pulse");
		end
		check_value("output latency", 32'(cycles), 32'(LATENCY));
		check_value("y_o", {8'd0, y_o}, {8'd0, expected_y(sum)});
		sine_idx_m = sine_idx_m + 4'd1;
		@(negedge clk_i);
		check_value("valid_strobe_o width", {31'd0, valid_strobe_o}, 32'd0);
		reg_read(`FIR_REG_RESULT, rd);
		check_value("result readback", rd, 32'(sum));
		reg_read(`FIR_REG_SHIFT_OUT, rd);
		check_value("shift_out readback", rd, 32'(hist_m[NUM_TAPS-1]));
	endtask

	initial begin
		logic [31:0] rd;
		fir_pkg::coef_t c;
		fir_pkg::sample_t x;
		fir_pkg::sample_t inj;
		seed = 40228;
		rst_ni = 1'b0;
		valid_strobe_i = 1'b0;
		sample_i = '0;
		reg_we_i = 1'b0;
		reg_addr_i = '0;
		reg_wdata_i = '0;
		shift_m = `FIR_SHIFT_RESET;
		sine_en_m = 1'b0;
		sine_idx_m = 4'd0;
		for (int k = 0; k < NUM_TAPS; k++) begin
			coef_m[k] = '0;
			hist_m[k] = '0;
		end
		repeat (16) @(negedge clk_i);
		rst_ni = 1'b1;

		// reset state
		expect_quiet(10);
		reg_read(`FIR_REG_RESULT, rd);
		check_value("result after reset", rd, 32'd0);
		reg_read(`FIR_REG_CTRL, rd);
		check_value("ctrl after reset", rd, 32'(`FIR_SHIFT_RESET) << 4);

		// small coefficients keep every segment partial sum inside acc_t
		for (int k = 0; k < NUM_TAPS; k++) begin
			c = fir_pkg::coef_t'($random(seed) % 64);
			coef_m[k] = c;
			reg_write(fir_pkg::reg_addr_t'(`FIR_REG_COEF_BASE + k), 32'(c));
		end

		// filtering at shift 0 over enough samples to fill both segments
		repeat (40) begin
			x = fir_pkg::sample_t'($random(seed));
			send_sample(x, x, 1);
		end

		// strobe still high when the segments go idle again
		x = fir_pkg::sample_t'($random(seed));
		send_sample(x, x, LATENCY);
		expect_quiet(20);

		// output shift of 3
		reg_write(`FIR_REG_CTRL, 32'h30);
		shift_m = 4'd3;
		repeat (6) begin
			x = fir_pkg::sample_t'($random(seed));
			send_sample(x, x, 1);
		end

		// injected sample replaces exactly one port sample
		inj = fir_pkg::sample_t'($random(seed));
		reg_write(`FIR_REG_INJECT, 32'(inj));
		x = ~inj;
		send_sample(x, inj, 1);
		x = fir_pkg::sample_t'($random(seed));
		send_sample(x, x, 1);

		// test tone over more than one table period
		reg_write(`FIR_REG_CTRL, 32'h31);
		sine_en_m = 1'b1;
		repeat (20) begin
			x = fir_pkg::sample_t'($random(seed));
			send_sample(x, x, 1);
		end

		// back to the filter path
		reg_write(`FIR_REG_CTRL, 32'h00);
		sine_en_m = 1'b0;
		shift_m = 4'd0;
		repeat (4) begin
			x = fir_pkg::sample_t'($random(seed));
			send_sample(x, x, 1);
		end

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+.
fir_pkg.sv
fir_segment.sv
fir_adder_tree.sv
fir_reg_file.sv
fir_sine_gen.sv
fir_parallel.sv
tb_fir_parallel.sv

// ==== run.sh ====
#!/bin/sh
# build and run the FIR testbench with Verilator, exit status is the result
cd "$(dirname "$0")" && \
verilator --binary --timing -Wno-fatal -f list.f \
	--top-module tb_fir_parallel -o tb_fir_parallel && \
./obj_dir/tb_fir_parallel || exit 1
